// ==== sim.f ====
+incdir+hw
hw/evr_link_pkg.sv
hw/evr_regs_pkg.sv
hw/evr_link_codec.sv
hw/evr_link_parser.sv
hw/evr_regs.sv
hw/evr_top.sv
testbench/tb_clock_gen.sv
testbench/tb_evr.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_evr -f sim.f

sim_status=0
./obj_dir/Vtb_evr > sim.log 2>&1 || sim_status=$?
cat sim.log

if grep -q "Finished with errors" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
if [ "$sim_status" -ne 0 ] || ! grep -q "Finished with no errors" sim.log; then
    echo "Simulation did not complete"
    exit 1
fi
echo "Simulation PASSED"

// ==== testbench/tb_evr.sv ====
`default_nettype none

`include "evr_macros.svh"

module tb_evr;

    localparam int RST_CYCLES  = 8;
    localparam int N_RAND      = 300;
    localparam int N_PKT       = 3;
    localparam int PKT_CYCLES  = `EVR_PKT_BYTES + 3;
    localparam int N_MMR       = 40;
    localparam int MMR_CYCLES  = 8;
    localparam int CYCLE_LIMIT = RST_CYCLES + N_RAND + N_PKT * PKT_CYCLES
                                 + N_MMR * MMR_CYCLES + 64;

    logic                     rx_clk;
    logic                     app_rst;
    logic                     aligned;
    evr_link_pkg::link_word_t rx_word;
    evr_link_pkg::link_word_t tx_word;
    logic [7:0]               ev;
    evr_regs_pkg::mmr_req_t   mmr_req;
    evr_regs_pkg::mmr_rsp_t   mmr_rsp;

    logic [31:0]              lfsr_q = 32'h9fc7_7ed0;
    evr_link_pkg::link_info_t exp_info;
    evr_regs_pkg::cr_t        exp_cr;
    evr_regs_pkg::mmr_data_t  exp_tgt;
    evr_link_pkg::link_word_t prev_rx = '0;
    logic                     prev_rst = 1'b1;
    logic [1:0]               phase_mdl = 2'd0;
    int                       cycle_cnt = 0;
    int                       err_cnt = 0;

    tb_clock_gen u_clk (
        .rx_clk_o  (rx_clk),
        .app_rst_o (app_rst)
    );

    evr_top uut (
        .rx_clk    (rx_clk),
        .app_rst   (app_rst),
        .aligned_i (aligned),
        .rx_word_i (rx_word),
        .tx_word_o (tx_word),
        .ev_o      (ev),
        .mmr_req_i (mmr_req),
        .mmr_rsp_o (mmr_rsp)
    );

    task automatic abort_run();
        $display("Finished with errors");
        $fatal(1, "Simulation stopped after a failure");
    endtask

    task automatic compare_lane(input string name, input evr_link_pkg::lane_t got,
                                input evr_link_pkg::lane_t exp);
        if (got !== exp) begin
            err_cnt++;
            $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic compare_ev(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            err_cnt++;
            $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic compare_data(input string name, input evr_regs_pkg::mmr_data_t got,
                                input evr_regs_pkg::mmr_data_t exp);
        if (got !== exp) begin
            err_cnt++;
            $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            err_cnt++;
            $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic next_cycle();
        @(posedge rx_clk);
        #2;
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
        return v;
    endfunction

    function automatic logic [7:0] expected_ev(input evr_link_pkg::link_word_t w);
        if (w.lo.k || w.lo.data == 8'h00 || w.lo.data == `EVR_BEACON) begin
            return 8'h00;
        end
        return w.lo.data;
    endfunction

    function automatic evr_link_pkg::lane_t expected_tx_lo(input evr_link_pkg::link_word_t w,
                                                           input logic [1:0] phase);
        if (!w.lo.k && w.lo.data == `EVR_BEACON) begin
            return '{data: `EVR_BEACON, k: 1'b0};
        end else if (phase == 2'd0) begin
            return '{data: `EVR_K_COMMA, k: 1'b1};
        end
        return '0;
    endfunction

    // abort_at past the last byte means a complete packet
    function automatic evr_link_pkg::link_info_t packet_info(
        input evr_link_pkg::link_info_t prev,
        input logic [63:0]              payload,
        input int                       abort_at
    );
        evr_link_pkg::link_info_t nxt;
        nxt = prev;
        if (abort_at < `EVR_PKT_BYTES) begin
            nxt.status.error = 1'b1;
        end else begin
            nxt.status = '{topo_valid: 1'b1, delay_valid: 1'b1, error: 1'b0};
            nxt.topoid = payload[63:32];
            nxt.delay  = payload[31:0];
        end
        return nxt;
    endfunction

    function automatic evr_regs_pkg::mmr_data_t read_model(input evr_regs_pkg::mmr_addr_t addr);
        evr_regs_pkg::sr_t sr;
        sr.link_delay_st = exp_info.status;
        sr.link_up       = aligned;
        case (addr)
            `EVR_REG_SR:         return evr_regs_pkg::mmr_data_t'(sr);
            `EVR_REG_CR:         return evr_regs_pkg::mmr_data_t'(exp_cr);
            `EVR_REG_TOPO_ID:    return exp_info.topoid;
            `EVR_REG_LINK_DELAY: return exp_info.delay;
            `EVR_REG_TGT_DELAY:  return exp_tgt;
            `EVR_REG_COMP_DELAY: return exp_tgt - exp_info.delay;
            default:             return '0;
        endcase
    endfunction

    task automatic apply_write(input evr_regs_pkg::mmr_addr_t addr,
                               input evr_regs_pkg::mmr_data_t data);
        if (addr == `EVR_REG_CR) begin
            exp_cr.dc_ena = data[0];
        end else if (addr == `EVR_REG_CR_S) begin
            exp_cr.dc_ena = exp_cr.dc_ena | data[0];
        end else if (addr == `EVR_REG_CR_C) begin
            exp_cr.dc_ena = exp_cr.dc_ena & ~data[0];
        end else if (addr == `EVR_REG_TGT_DELAY && data > exp_info.delay) begin
            exp_tgt = data;
        end
        if (!aligned) begin
            exp_cr.dc_ena = 1'b0;
        end
    endtask

    task automatic mmr_write(input evr_regs_pkg::mmr_addr_t addr,
                             input evr_regs_pkg::mmr_data_t data);
        logic aw_ok;
        logic w_ok;
        aw_ok = 1'b0;
        w_ok  = 1'b0;
        mmr_req.awaddr  = addr;
        mmr_req.awvalid = 1'b1;
        mmr_req.wdata   = data;
        mmr_req.wvalid  = 1'b1;
        while (!(aw_ok && w_ok)) begin
            next_cycle();
            if (mmr_rsp.awready) begin
                aw_ok = 1'b1;
                mmr_req.awvalid = 1'b0;
            end
            if (mmr_rsp.wready) begin
                w_ok = 1'b1;
                mmr_req.wvalid = 1'b0;
            end
        end
        while (!mmr_rsp.bvalid) begin
            next_cycle();
        end
        mmr_req.bready = 1'b1;
        next_cycle();
        mmr_req.bready = 1'b0;
        apply_write(addr, data);
    endtask

    // hold keeps rready low for that many cycles once rvalid is up
    task automatic mmr_read(input evr_regs_pkg::mmr_addr_t addr, input int hold,
                            output evr_regs_pkg::mmr_data_t data);
        mmr_req.araddr  = addr;
        mmr_req.arvalid = 1'b1;
        next_cycle();
        while (!mmr_rsp.arready) begin
            next_cycle();
        end
        mmr_req.arvalid = 1'b0;
        while (!mmr_rsp.rvalid) begin
            next_cycle();
        end
        repeat (hold) begin
            next_cycle();
            compare_flag("mmr_rsp_o.rvalid", mmr_rsp.rvalid, 1'b1);
        end
        data = mmr_rsp.rdata;
        mmr_req.rready = 1'b1;
        next_cycle();
        mmr_req.rready = 1'b0;
        compare_flag("mmr_rsp_o.rvalid", mmr_rsp.rvalid, 1'b0);
    endtask

    task automatic check_read(input evr_regs_pkg::mmr_addr_t addr);
        evr_regs_pkg::mmr_data_t got;
        mmr_read(addr, 0, got);
        compare_data($sformatf("mmr_rsp_o.rdata (addr 0x%h)", addr), got, read_model(addr));
    endtask

    task automatic send_packet(input logic [63:0] payload, input int abort_at);
        int i;
        rx_word.hi = '{data: `EVR_K_PKT_START, k: 1'b1};
        next_cycle();
        for (i = 0; i < `EVR_PKT_BYTES; i++) begin
            if (i == abort_at) begin
                rx_word.hi = '{data: `EVR_K_COMMA, k: 1'b1};
            end else begin
                rx_word.hi = '{data: payload[63 - 8 * i -: 8], k: 1'b0};
            end
            next_cycle();
        end
        rx_word.hi = '0;
        next_cycle();
        exp_info = packet_info(exp_info, payload, abort_at);
    endtask

    // Outputs settle by the falling edge; the inputs seen now are taken at the next rise
    always @(negedge rx_clk) begin
        if (prev_rst) begin
            compare_ev("ev_o", ev, 8'h00);
            compare_lane("tx_word_o.lo", tx_word.lo, '0);
            phase_mdl = 2'd0;
        end else begin
            compare_ev("ev_o", ev, expected_ev(prev_rx));
            compare_lane("tx_word_o.lo", tx_word.lo, expected_tx_lo(prev_rx, phase_mdl));
            phase_mdl = phase_mdl + 2'd1;
        end
        compare_lane("tx_word_o.hi", tx_word.hi, '0);
        prev_rx  = rx_word;
        prev_rst = app_rst;
    end

    always @(posedge rx_clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > CYCLE_LIMIT) begin
            $display("Timeout: test did not end within %0d cycles", CYCLE_LIMIT);
            abort_run();
        end
    end

    initial begin
        logic [31:0]             rv;
        evr_regs_pkg::mmr_data_t rd;
        int                      i;
        aligned  = 1'b0;
        rx_word  = '0;
        mmr_req  = '0;
        exp_info = '0;
        exp_cr   = '0;
        exp_tgt  = '0;
        wait (app_rst === 1'b1);
        wait (app_rst === 1'b0);

        compare_ev("ev_o", ev, 8'h00);
        compare_flag("mmr_rsp_o.awready", mmr_rsp.awready, 1'b0);
        compare_flag("mmr_rsp_o.wready", mmr_rsp.wready, 1'b0);
        compare_flag("mmr_rsp_o.bvalid", mmr_rsp.bvalid, 1'b0);
        compare_flag("mmr_rsp_o.arready", mmr_rsp.arready, 1'b0);
        compare_flag("mmr_rsp_o.rvalid", mmr_rsp.rvalid, 1'b0);
        aligned = 1'b1;
        next_cycle();
        check_read(`EVR_REG_SR);
        check_read(`EVR_REG_CR);
        check_read(`EVR_REG_TGT_DELAY);
        check_read(8'h20);

        // Random events, K-codes and beacons on the low lane
        for (i = 0; i < N_RAND; i++) begin
            rv = rand_bits(8);
            rx_word.lo.data = rv[7:0];
            rx_word.lo.k    = rand_bits(2) == 32'd3;
            if (rand_bits(3) == 32'd0) begin
                rx_word.lo = '{data: `EVR_BEACON, k: 1'b0};
            end
            next_cycle();
        end
        rx_word.lo = '0;

        send_packet(64'h0001_a5c3_0000_0480, `EVR_PKT_BYTES);
        check_read(`EVR_REG_SR);
        check_read(`EVR_REG_TOPO_ID);
        check_read(`EVR_REG_LINK_DELAY);
        send_packet(64'hdead_beef_0000_1234, 5);
        check_read(`EVR_REG_SR);
        check_read(`EVR_REG_TOPO_ID);
        check_read(`EVR_REG_LINK_DELAY);
        send_packet(64'h0002_7710_0000_0400, `EVR_PKT_BYTES);
        check_read(`EVR_REG_SR);
        check_read(`EVR_REG_TOPO_ID);
        check_read(`EVR_REG_LINK_DELAY);

        // Target below the link delay must not stick
        mmr_write(`EVR_REG_TGT_DELAY, 32'h0000_0100);
        check_read(`EVR_REG_TGT_DELAY);
        mmr_write(`EVR_REG_TGT_DELAY, 32'h0000_0a00);
        check_read(`EVR_REG_TGT_DELAY);
        check_read(`EVR_REG_COMP_DELAY);
        mmr_read(`EVR_REG_COMP_DELAY, 4, rd);
        compare_data("mmr_rsp_o.rdata (held read)", rd, read_model(`EVR_REG_COMP_DELAY));

        mmr_write(`EVR_REG_CR, 32'h0000_0001);
        check_read(`EVR_REG_CR);
        mmr_write(`EVR_REG_CR_C, 32'h0000_0001);
        check_read(`EVR_REG_CR);
        mmr_write(`EVR_REG_CR_S, 32'h0000_0001);
        check_read(`EVR_REG_CR);
        mmr_write(`EVR_REG_CR_S, 32'h0000_0000);
        check_read(`EVR_REG_CR);
        mmr_write(8'h24, 32'hffff_fffe);
        check_read(`EVR_REG_CR);
        check_read(`EVR_REG_TGT_DELAY);

        // Link loss drops dc_ena and the parse status
        aligned = 1'b0;
        next_cycle();
        next_cycle();
        exp_cr.dc_ena   = 1'b0;
        exp_info.status = '0;
        check_read(`EVR_REG_SR);
        check_read(`EVR_REG_CR);
        mmr_write(`EVR_REG_CR_S, 32'h0000_0001);
        check_read(`EVR_REG_CR);
        aligned = 1'b1;
        next_cycle();
        check_read(`EVR_REG_SR);
        check_read(`EVR_REG_TOPO_ID);

        if (err_cnt == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            abort_run();
        end
    end

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen (
    output logic rx_clk_o,
    output logic app_rst_o
);

    localparam int RST_CYCLES = 8;

    // 20-unit period
    initial begin
        rx_clk_o = 1'b0;
        forever #10 rx_clk_o = ~rx_clk_o;
    end

    // Released just after the edge, like the other inputs
    initial begin
        app_rst_o = 1'b1;
        repeat (RST_CYCLES) @(posedge rx_clk_o);
        #2 app_rst_o = 1'b0;
    end

endmodule

`default_nettype wire

// ==== hw/evr_top.sv ====
`default_nettype none

module evr_top (
    input  logic                     rx_clk,
    input  logic                     app_rst,
    input  logic                     aligned_i,
    input  evr_link_pkg::link_word_t rx_word_i,
    output evr_link_pkg::link_word_t tx_word_o,
    output logic [7:0]               ev_o,
    input  evr_regs_pkg::mmr_req_t   mmr_req_i,
    output evr_regs_pkg::mmr_rsp_t   mmr_rsp_o
);

    evr_link_pkg::link_info_t link_info;

    // Low lane events, beacon echo and tx framing
    evr_link_codec u_codec (
        .rx_clk    (rx_clk),
        .app_rst   (app_rst),
        .rx_word_i (rx_word_i),
        .ev_o      (ev_o),
        .tx_word_o (tx_word_o)
    );

    // High lane link-information packets
    evr_link_parser u_parser (
        .rx_clk      (rx_clk),
        .app_rst     (app_rst),
        .link_up_i   (aligned_i),
        .rx_lane_i   (rx_word_i.hi),
        .link_info_o (link_info)
    );

    evr_regs u_regs (
        .rx_clk      (rx_clk),
        .app_rst     (app_rst),
        .link_up_i   (aligned_i),
        .link_info_i (link_info),
        .mmr_req_i   (mmr_req_i),
        .mmr_rsp_o   (mmr_rsp_o)
    );

endmodule

`default_nettype wire

// ==== hw/evr_regs.sv ====
`default_nettype none

`include "evr_macros.svh"

module evr_regs (
    input  logic                     rx_clk,
    input  logic                     app_rst,
    input  logic                     link_up_i,
    input  evr_link_pkg::link_info_t link_info_i,
    input  evr_regs_pkg::mmr_req_t   mmr_req_i,
    output evr_regs_pkg::mmr_rsp_t   mmr_rsp_o
);

    evr_regs_pkg::sr_t        sr;
    evr_regs_pkg::cr_t        cr_q;
    evr_regs_pkg::mmr_data_t  tgt_delay_q;
    evr_regs_pkg::mmr_data_t  comp_delay;
    evr_regs_pkg::mmr_data_t  rd_mux;
    evr_regs_pkg::mmr_data_t  rdata_q;
    evr_regs_pkg::mmr_addr_t  rd_addr;
    evr_regs_pkg::mmr_addr_t  wr_addr;
    evr_regs_pkg::mmr_wdata_u wdata_q;

    logic rd_pend;
    logic aw_done;
    logic w_done;
    logic arready_q;
    logic rvalid_q;
    logic awready_q;
    logic wready_q;
    logic bvalid_q;
    logic wr_commit;

    assign sr.link_up       = link_up_i;
    assign sr.link_delay_st = link_info_i.status;

    // Correction still to be applied
    assign comp_delay = tgt_delay_q - link_info_i.delay;

    assign wr_commit = bvalid_q && mmr_req_i.bready;

    always_comb begin
        case (rd_addr)
            `EVR_REG_SR:         rd_mux = evr_regs_pkg::mmr_data_t'(sr);
            `EVR_REG_CR:         rd_mux = evr_regs_pkg::mmr_data_t'(cr_q);
            `EVR_REG_TOPO_ID:    rd_mux = link_info_i.topoid;
            `EVR_REG_LINK_DELAY: rd_mux = link_info_i.delay;
            `EVR_REG_TGT_DELAY:  rd_mux = tgt_delay_q;
            `EVR_REG_COMP_DELAY: rd_mux = comp_delay;
            default:             rd_mux = '0;
        endcase
    end

    // Read channel
    always_ff @(posedge rx_clk) begin
        if (app_rst) begin
            arready_q <= 1'b0;
            rvalid_q  <= 1'b0;
            rd_pend   <= 1'b0;
        end else begin
            arready_q <= 1'b0;
            if (mmr_req_i.arvalid && !rd_pend) begin
                rd_pend   <= 1'b1;
                arready_q <= 1'b1;
            end
            if (rd_pend && !rvalid_q) begin
                rvalid_q <= 1'b1;
            end
            if (rvalid_q && mmr_req_i.rready) begin
                rvalid_q <= 1'b0;
                rd_pend  <= 1'b0;
            end
        end
    end

    always_ff @(posedge rx_clk) begin
        if (mmr_req_i.arvalid && !rd_pend) begin
            rd_addr <= mmr_req_i.araddr;
        end
        // Data is frozen while rvalid is up
        if (rd_pend && !rvalid_q) begin
            rdata_q <= rd_mux;
        end
    end

    // Write channel, address and data taken independently
    always_ff @(posedge rx_clk) begin
        if (app_rst) begin
            awready_q <= 1'b0;
            wready_q  <= 1'b0;
            bvalid_q  <= 1'b0;
            aw_done   <= 1'b0;
            w_done    <= 1'b0;
        end else begin
            awready_q <= 1'b0;
            if (mmr_req_i.awvalid && !aw_done) begin
                aw_done   <= 1'b1;
                awready_q <= 1'b1;
            end
            wready_q <= 1'b0;
            if (mmr_req_i.wvalid && !w_done) begin
                w_done   <= 1'b1;
                wready_q <= 1'b1;
            end
            if (aw_done && w_done && !bvalid_q) begin
                bvalid_q <= 1'b1;
            end
            if (wr_commit) begin
                bvalid_q <= 1'b0;
                aw_done  <= 1'b0;
                w_done   <= 1'b0;
            end
        end
    end

    always_ff @(posedge rx_clk) begin
        if (mmr_req_i.awvalid && !aw_done) begin
            wr_addr <= mmr_req_i.awaddr;
        end
        if (mmr_req_i.wvalid && !w_done) begin
            wdata_q <= mmr_req_i.wdata;
        end
    end

    // Register updates on write response
    always_ff @(posedge rx_clk) begin
        if (app_rst) begin
            cr_q        <= '0;
            tgt_delay_q <= '0;
        end else begin
            if (wr_commit) begin
                case (wr_addr)
                    `EVR_REG_CR:   cr_q <= wdata_q.ctrl.cr;
                    `EVR_REG_CR_S: cr_q <= cr_q | wdata_q.ctrl.cr;
                    `EVR_REG_CR_C: cr_q <= cr_q & ~wdata_q.ctrl.cr;
                    `EVR_REG_TGT_DELAY: begin
                        // Target must lie beyond the measured delay
                        if (wdata_q.delay > link_info_i.delay) begin
                            tgt_delay_q <= wdata_q.delay;
                        end
                    end
                    default: ;
                endcase
            end
            if (!link_up_i) begin
                cr_q.dc_ena <= 1'b0;
            end
        end
    end

    assign mmr_rsp_o.awready = awready_q;
    assign mmr_rsp_o.wready  = wready_q;
    assign mmr_rsp_o.bvalid  = bvalid_q;
    assign mmr_rsp_o.arready = arready_q;
    assign mmr_rsp_o.rvalid  = rvalid_q;
    assign mmr_rsp_o.rdata   = rdata_q;

endmodule

`default_nettype wire

// ==== hw/evr_link_parser.sv ====
`default_nettype none

`include "evr_macros.svh"

module evr_link_parser (
    input  logic                     rx_clk,
    input  logic                     app_rst,
    input  logic                     link_up_i,
    input  evr_link_pkg::lane_t      rx_lane_i,
    output evr_link_pkg::link_info_t link_info_o
);

    typedef enum logic {
        S_IDLE,
        S_PAYLOAD
    } state_t;

    state_t                     state;
    logic [2:0]                 byte_cnt;
    logic [63:0]                shift_q;
    logic [63:0]                pkt_full;
    logic                       pkt_start;
    logic                       pkt_last;
    evr_link_pkg::link_status_t status_q;
    logic [31:0]                topoid_q;
    logic [31:0]                delay_q;

    assign pkt_start = rx_lane_i.k && rx_lane_i.data == `EVR_K_PKT_START;
    assign pkt_last  = byte_cnt == 3'(`EVR_PKT_BYTES - 1);

    // Whole packet including the byte arriving now
    assign pkt_full = {shift_q[55:0], rx_lane_i.data};

    always_ff @(posedge rx_clk) begin
        if (app_rst || !link_up_i) begin
            state    <= S_IDLE;
            byte_cnt <= 3'd0;
            status_q <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    byte_cnt <= 3'd0;
                    if (pkt_start) begin
                        state <= S_PAYLOAD;
                    end
                end
                S_PAYLOAD: begin
                    if (rx_lane_i.k) begin
                        // Aborted, last good values stay
                        state          <= S_IDLE;
                        status_q.error <= 1'b1;
                    end else if (pkt_last) begin
                        state    <= S_IDLE;
                        status_q <= '{topo_valid: 1'b1, delay_valid: 1'b1, error: 1'b0};
                    end else begin
                        byte_cnt <= byte_cnt + 3'd1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Payload collection, MSB first
    always_ff @(posedge rx_clk) begin
        if (state == S_PAYLOAD && !rx_lane_i.k) begin
            shift_q <= pkt_full;
            if (pkt_last) begin
                topoid_q <= pkt_full[63:32];
                delay_q  <= pkt_full[31:0];
            end
        end
    end

    assign link_info_o.status = status_q;
    assign link_info_o.topoid = topoid_q;
    assign link_info_o.delay  = delay_q;

endmodule

`default_nettype wire

// ==== hw/evr_link_codec.sv ====
`default_nettype none

`include "evr_macros.svh"

module evr_link_codec (
    input  logic                     rx_clk,
    input  logic                     app_rst,
    input  evr_link_pkg::link_word_t rx_word_i,
    output logic [7:0]               ev_o,
    output evr_link_pkg::link_word_t tx_word_o
);

    logic                rx_beacon;
    logic                rx_event;
    logic [1:0]          phase;
    evr_link_pkg::lane_t tx_lo_next;

    // Beacon is a plain data byte, never a K-code
    assign rx_beacon = !rx_word_i.lo.k && rx_word_i.lo.data == `EVR_BEACON;

    // Event codes exclude idle zero and the beacon
    assign rx_event = !rx_word_i.lo.k
                      && rx_word_i.lo.data != 8'h00
                      && rx_word_i.lo.data != `EVR_BEACON;

    // Echoed beacon wins over the comma slot
    always_comb begin
        if (rx_beacon) begin
            tx_lo_next.data = `EVR_BEACON;
            tx_lo_next.k    = 1'b0;
        end else if (phase == 2'd0) begin
            tx_lo_next.data = `EVR_K_COMMA;
            tx_lo_next.k    = 1'b1;
        end else begin
            tx_lo_next.data = 8'h00;
            tx_lo_next.k    = 1'b0;
        end
    end

    always_ff @(posedge rx_clk) begin
        if (app_rst) begin
            phase <= 2'd0;
        end else begin
            phase <= phase + 2'd1;
        end
    end

    // Event output, one cycle behind the receive word
    always_ff @(posedge rx_clk) begin
        if (app_rst) begin
            ev_o <= 8'h00;
        end else if (rx_event) begin
            ev_o <= rx_word_i.lo.data;
        end else begin
            ev_o <= 8'h00;
        end
    end

    // Transmit word, high lane idle
    always_ff @(posedge rx_clk) begin
        if (app_rst) begin
            tx_word_o <= '0;
        end else begin
            tx_word_o.hi.data <= 8'h00;
            tx_word_o.hi.k    <= 1'b0;
            tx_word_o.lo      <= tx_lo_next;
        end
    end

endmodule

`default_nettype wire

// ==== hw/evr_regs_pkg.sv ====
`default_nettype none

`include "evr_macros.svh"

package evr_regs_pkg;

    typedef logic [`EVR_MMR_ADDR_W-1:0] mmr_addr_t;
    typedef logic [`EVR_MMR_DATA_W-1:0] mmr_data_t;

    // Master to slave
    typedef struct packed {
        logic      awvalid;
        mmr_addr_t awaddr;
        logic      wvalid;
        mmr_data_t wdata;
        logic      bready;
        logic      arvalid;
        mmr_addr_t araddr;
        logic      rready;
    } mmr_req_t;

    // Slave to master
    typedef struct packed {
        logic      awready;
        logic      wready;
        logic      bvalid;
        logic      arready;
        logic      rvalid;
        mmr_data_t rdata;
    } mmr_rsp_t;

    typedef struct packed {
        logic [2:0] link_delay_st;
        logic       link_up;
    } sr_t;

    typedef struct packed {
        logic dc_ena;
    } cr_t;

    typedef struct packed {
        logic [`EVR_MMR_DATA_W-2:0] pad;
        cr_t                        cr;
    } cr_view_t;

    // Write data seen as a delay value or as control bits
    typedef union packed {
        mmr_data_t delay;
        cr_view_t  ctrl;
    } mmr_wdata_u;

endpackage

`default_nettype wire

// ==== hw/evr_link_pkg.sv ====
`default_nettype none

package evr_link_pkg;

    // One byte lane of the serial word
    typedef struct packed {
        logic [7:0] data;
        logic       k;
    } lane_t;

    // High lane carries packets, low lane events and beacons
    typedef struct packed {
        lane_t hi;
        lane_t lo;
    } link_word_t;

    typedef struct packed {
        logic topo_valid;
        logic delay_valid;
        logic error;
    } link_status_t;

    // Decoded link information from the packet parser
    typedef struct packed {
        link_status_t status;
        logic [31:0]  topoid;
        logic [31:0]  delay;
    } link_info_t;

endpackage

`default_nettype wire

// ==== hw/evr_macros.svh ====
`ifndef EVR_MACROS_SVH
`define EVR_MACROS_SVH

// Link K-codes and fixed symbols
`define EVR_K_COMMA        8'hBC
`define EVR_BEACON         8'h7E
`define EVR_K_PKT_START    8'h1C

// Link-info packet payload, topology id then delay
`define EVR_PKT_BYTES      8

// Register bus
`define EVR_MMR_ADDR_W     8
`define EVR_MMR_DATA_W     32

// Register map
`define EVR_REG_SR         8'h00
`define EVR_REG_CR         8'h04
`define EVR_REG_CR_S       8'h08
`define EVR_REG_CR_C       8'h0C
`define EVR_REG_TOPO_ID    8'h10
`define EVR_REG_LINK_DELAY 8'h14
`define EVR_REG_TGT_DELAY  8'h18
`define EVR_REG_COMP_DELAY 8'h1C

`endif
